// File: verilog/memsys_pkg.sv
`default_nettype none

package memsys_pkg;

    localparam int xlen = 64;
    localparam int line_bytes = 64;
    localparam int line_bits = line_bytes * 8;
    localparam int cache_sets = 32;
    localparam int cache_ways = 2;
    localparam int offset_bits = $clog2(line_bytes);
    localparam int index_bits = $clog2(cache_sets);
    localparam int tag_bits = xlen - index_bits - offset_bits;

    // backing memory, 16 KB
    localparam int mem_lines = 256;
    localparam int mem_index_bits = $clog2(mem_lines);
    localparam int mem_latency = 3;
    localparam int mem_count_bits = $clog2(mem_latency + 1);
    localparam logic [mem_count_bits-1:0] mem_last_count = mem_count_bits'(mem_latency - 1);

    typedef logic [line_bits-1:0] line_t;
    typedef logic [xlen-offset_bits-1:0] line_addr_t;

    typedef enum logic [2:0] {
        no_load,
        load_byte,
        load_half,
        load_word,
        load_dword
    } load_type_t;

    typedef enum logic [2:0] {
        no_store,
        store_byte,
        store_half,
        store_word,
        store_dword
    } store_type_t;

    typedef struct packed {
        load_type_t        load_type;
        store_type_t       store_type;
        logic              signed_type;
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   wdata;
    } core_req_t;

    typedef struct packed {
        logic       req_load;
        logic       req_store;
        line_addr_t line_addr;
        line_t      wdata;
    } mem_bus_req_t;

    typedef struct packed {
        logic  ready;
        line_t rdata;
    } mem_bus_resp_t;

    typedef struct packed {
        logic access_done;
        logic refill;
        logic writeback;
    } cache_event_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

    // register offsets
    localparam logic [11:0] csr_ctrl = 12'h0;
    localparam logic [11:0] csr_access_count = 12'h4;
    localparam logic [11:0] csr_refill_count = 12'h8;
    localparam logic [11:0] csr_writeback_count = 12'hC;

endpackage

`default_nettype wire

// File: verilog/byte_lane_unit.sv
`timescale 1ns/1ps
`default_nettype none

module byte_lane_unit (
    input  memsys_pkg::line_t                  line,
    input  logic [memsys_pkg::offset_bits-1:0] offset,
    input  memsys_pkg::load_type_t             load_type,
    input  logic                               signed_type,
    input  memsys_pkg::store_type_t            store_type,
    input  logic [memsys_pkg::xlen-1:0]        wdata,
    output logic [memsys_pkg::xlen-1:0]        load_data,
    output memsys_pkg::line_t                  merged_line
);

    logic [memsys_pkg::offset_bits+2:0] bit_pos;
    logic [7:0] lane_b;
    logic [15:0] lane_h;
    logic [31:0] lane_w;

    always_comb begin
        bit_pos = {offset, 3'b000};
        lane_b = line[bit_pos+:8];
        lane_h = line[bit_pos+:16];
        lane_w = line[bit_pos+:32];
        // sign bit only used when signed_type is set
        case (load_type)
            memsys_pkg::load_byte: load_data = {{56{signed_type & lane_b[7]}}, lane_b};
            memsys_pkg::load_half: load_data = {{48{signed_type & lane_h[15]}}, lane_h};
            memsys_pkg::load_word: load_data = {{32{signed_type & lane_w[31]}}, lane_w};
            memsys_pkg::load_dword: load_data = line[bit_pos+:64];
            default: load_data = '0;
        endcase
    end

    always_comb begin
        merged_line = line;
        case (store_type)
            memsys_pkg::store_byte: merged_line[bit_pos+:8] = wdata[7:0];
            memsys_pkg::store_half: merged_line[bit_pos+:16] = wdata[15:0];
            memsys_pkg::store_word: merged_line[bit_pos+:32] = wdata[31:0];
            memsys_pkg::store_dword: merged_line[bit_pos+:64] = wdata;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/l1_data_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_data_cache (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          enable,
    input  memsys_pkg::core_req_t         core_req,
    output logic [memsys_pkg::xlen-1:0]   rdata,
    output logic                          miss,
    output memsys_pkg::cache_event_t      events,
    output memsys_pkg::mem_bus_req_t      mem_req,
    input  memsys_pkg::mem_bus_resp_t     mem_resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_writeback,
        st_refill
    } state_t;

    logic [memsys_pkg::tag_bits-1:0] tag_arr [memsys_pkg::cache_ways][memsys_pkg::cache_sets];
    logic valid_arr [memsys_pkg::cache_ways][memsys_pkg::cache_sets];
    logic dirty_arr [memsys_pkg::cache_ways][memsys_pkg::cache_sets];
    logic lru_arr [memsys_pkg::cache_sets];
    memsys_pkg::line_t data_arr [memsys_pkg::cache_ways][memsys_pkg::cache_sets];

    logic [memsys_pkg::tag_bits-1:0] tag;
    logic [memsys_pkg::index_bits-1:0] index;
    logic [memsys_pkg::offset_bits-1:0] offset;
    logic [memsys_pkg::cache_ways-1:0] way_hit;
    logic hit;
    logic hit_way;
    logic victim;
    logic victim_dirty;
    logic active;
    logic complete;
    logic is_store;
    memsys_pkg::line_t hit_line;
    memsys_pkg::line_t merged_line;
    logic [memsys_pkg::xlen-1:0] load_data;
    logic [2:0] align_mask;

    state_t state;
    logic req_load;
    logic req_store;
    memsys_pkg::line_addr_t req_line_addr;
    memsys_pkg::line_t req_wdata;

    always_comb begin
        {tag, index, offset} = core_req.addr;
        for (int w = 0; w < memsys_pkg::cache_ways; w++) begin
            way_hit[w] = valid_arr[w][index] && (tag_arr[w][index] == tag);
        end
        hit = |way_hit;
        hit_way = way_hit[1];
        victim = lru_arr[index];
        victim_dirty = valid_arr[victim][index] && dirty_arr[victim][index];
        hit_line = data_arr[hit_way][index];
        is_store = core_req.store_type != memsys_pkg::no_store;
        active = enable && (core_req.load_type != memsys_pkg::no_load || is_store);
        miss = active && !hit;
        // a hit can only exist in st_idle, the line is installed before leaving refill
        complete = active && hit;
    end

    always_comb begin
        events.access_done = complete;
        events.refill = (state == st_refill) && mem_resp.ready;
        events.writeback = (state == st_writeback) && mem_resp.ready;
    end

    assign mem_req = '{
        req_load: req_load,
        req_store: req_store,
        line_addr: req_line_addr,
        wdata: req_wdata
    };

    byte_lane_unit lanes0 (
        .line       (hit_line),
        .offset     (offset),
        .load_type  (core_req.load_type),
        .signed_type(core_req.signed_type),
        .store_type (core_req.store_type),
        .wdata      (core_req.wdata),
        .load_data  (load_data),
        .merged_line(merged_line)
    );

    // control state and sequencing
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= st_idle;
            req_load <= 1'b0;
            req_store <= 1'b0;
            valid_arr <= '{default: '{default: 1'b0}};
            dirty_arr <= '{default: '{default: 1'b0}};
            lru_arr <= '{default: 1'b0};
            rdata <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (complete) begin
                        if (core_req.load_type != memsys_pkg::no_load) begin
                            rdata <= load_data;
                        end
                        if (is_store) begin
                            dirty_arr[hit_way][index] <= 1'b1;
                        end
                        lru_arr[index] <= !hit_way;
                    end else if (miss) begin
                        if (victim_dirty) begin
                            req_store <= 1'b1;
                            state <= st_writeback;
                        end else begin
                            req_load <= 1'b1;
                            state <= st_refill;
                        end
                    end
                end
                st_writeback: begin
                    if (mem_resp.ready) begin
                        dirty_arr[victim][index] <= 1'b0;
                        req_store <= 1'b0;
                        req_load <= 1'b1;
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    if (mem_resp.ready) begin
                        valid_arr[victim][index] <= 1'b1;
                        dirty_arr[victim][index] <= 1'b0;
                        req_load <= 1'b0;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // arrays and bus payload
    always_ff @(posedge clock) begin
        if (complete && is_store) begin
            data_arr[hit_way][index] <= merged_line;
        end
        if (state == st_idle && miss) begin
            if (victim_dirty) begin
                req_line_addr <= {tag_arr[victim][index], index};
                req_wdata <= data_arr[victim][index];
            end else begin
                req_line_addr <= {tag, index};
            end
        end
        if (state == st_writeback && mem_resp.ready) begin
            req_line_addr <= {tag, index};
        end
        if (state == st_refill && mem_resp.ready) begin
            tag_arr[victim][index] <= tag;
            data_arr[victim][index] <= mem_resp.rdata;
        end
    end

    // low address bits that must be zero for the access size
    always_comb begin
        align_mask = 3'b000;
        case (core_req.load_type)
            memsys_pkg::load_half: align_mask = 3'b001;
            memsys_pkg::load_word: align_mask = 3'b011;
            memsys_pkg::load_dword: align_mask = 3'b111;
            default: ;
        endcase
        case (core_req.store_type)
            memsys_pkg::store_half: align_mask = align_mask | 3'b001;
            memsys_pkg::store_word: align_mask = align_mask | 3'b011;
            memsys_pkg::store_dword: align_mask = align_mask | 3'b111;
            default: ;
        endcase
    end

    req_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(mem_req.req_load && mem_req.req_store));

    access_aligned: assert property (@(posedge clock) disable iff (reset)
        active |-> ((core_req.addr[2:0] & align_mask) == 3'b000));

    req_addr_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_req.req_load || mem_req.req_store) && !mem_resp.ready
            |=> $stable(mem_req.line_addr));

endmodule

`default_nettype wire

// File: verilog/backing_memory.sv
`timescale 1ns/1ps
`default_nettype none

module backing_memory (
    input  logic                      clock,
    input  logic                      reset,
    input  memsys_pkg::mem_bus_req_t  req,
    output memsys_pkg::mem_bus_resp_t resp
);

    memsys_pkg::line_t mem [memsys_pkg::mem_lines];

    logic [memsys_pkg::mem_count_bits-1:0] count;
    logic [memsys_pkg::mem_index_bits-1:0] line_index;
    logic ready;
    logic pending;
    logic fire;
    memsys_pkg::line_t rdata;

    always_comb begin
        pending = req.req_load || req.req_store;
        line_index = req.line_addr[memsys_pkg::mem_index_bits-1:0];
        // last wait cycle, ready shows up on the next one
        fire = pending && !ready && (count == memsys_pkg::mem_last_count);
    end

    assign resp = '{ready: ready, rdata: rdata};

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            count <= '0;
            ready <= 1'b0;
            // byte a holds low byte of a xor 0x5a
            for (int l = 0; l < memsys_pkg::mem_lines; l++) begin
                for (int b = 0; b < memsys_pkg::line_bytes; b++) begin
                    mem[l][b*8+:8] <= 8'(l * memsys_pkg::line_bytes + b) ^ 8'h5a;
                end
            end
        end else if (ready) begin
            ready <= 1'b0;
            count <= '0;
        end else if (pending) begin
            count <= count + 1'b1;
            if (fire) begin
                ready <= 1'b1;
                if (req.req_store) begin
                    mem[line_index] <= req.wdata;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fire && req.req_load) begin
            rdata <= mem[line_index];
        end
    end

    req_held: assert property (@(posedge clock) disable iff (reset)
        pending && !ready |=> pending);

endmodule

`default_nettype wire

// File: verilog/cache_csr.sv
`timescale 1ns/1ps
`default_nettype none

module cache_csr (
    input  logic                     clock,
    input  logic                     reset,
    input  memsys_pkg::apb_req_t     apb,
    output memsys_pkg::apb_resp_t    apb_rsp,
    input  memsys_pkg::cache_event_t events,
    output logic                     enable
);

    logic [31:0] access_count;
    logic [31:0] refill_count;
    logic [31:0] writeback_count;
    logic access_phase;
    logic wr_en;
    logic mapped;

    always_comb begin
        access_phase = apb.psel && apb.penable;
        wr_en = access_phase && apb.pwrite;
        case (apb.paddr)
            memsys_pkg::csr_ctrl,
            memsys_pkg::csr_access_count,
            memsys_pkg::csr_refill_count,
            memsys_pkg::csr_writeback_count: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    // zero wait states
    always_comb begin
        apb_rsp.pready = access_phase;
        apb_rsp.pslverr = access_phase && !mapped;
        apb_rsp.prdata = '0;
        if (access_phase && !apb.pwrite) begin
            case (apb.paddr)
                memsys_pkg::csr_ctrl: apb_rsp.prdata = {31'b0, enable};
                memsys_pkg::csr_access_count: apb_rsp.prdata = access_count;
                memsys_pkg::csr_refill_count: apb_rsp.prdata = refill_count;
                memsys_pkg::csr_writeback_count: apb_rsp.prdata = writeback_count;
                default: apb_rsp.prdata = '0;
            endcase
        end
    end

    // a write clears a counter, even against an event in the same cycle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            enable <= 1'b1;
            access_count <= '0;
            refill_count <= '0;
            writeback_count <= '0;
        end else begin
            if (wr_en && apb.paddr == memsys_pkg::csr_ctrl) begin
                enable <= apb.pwdata[0];
            end

            if (wr_en && apb.paddr == memsys_pkg::csr_access_count) begin
                access_count <= '0;
            end else if (events.access_done) begin
                access_count <= access_count + 32'd1;
            end

            if (wr_en && apb.paddr == memsys_pkg::csr_refill_count) begin
                refill_count <= '0;
            end else if (events.refill) begin
                refill_count <= refill_count + 32'd1;
            end

            if (wr_en && apb.paddr == memsys_pkg::csr_writeback_count) begin
                writeback_count <= '0;
            end else if (events.writeback) begin
                writeback_count <= writeback_count + 32'd1;
            end
        end
    end

    penable_with_psel: assert property (@(posedge clock) disable iff (reset)
        apb.penable |-> apb.psel);

endmodule

`default_nettype wire

// File: verilog/memsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module memsys_top (
    input  logic                        clock,
    input  logic                        reset,
    input  memsys_pkg::apb_req_t        apb,
    output memsys_pkg::apb_resp_t       apb_rsp,
    input  memsys_pkg::core_req_t       core_req,
    output logic [memsys_pkg::xlen-1:0] rdata,
    output logic                        miss
);

    logic enable;
    memsys_pkg::cache_event_t events;
    memsys_pkg::mem_bus_req_t mem_req;
    memsys_pkg::mem_bus_resp_t mem_resp;

    cache_csr csr0 (
        .clock  (clock),
        .reset  (reset),
        .apb    (apb),
        .apb_rsp(apb_rsp),
        .events (events),
        .enable (enable)
    );

    l1_data_cache cache0 (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .core_req(core_req),
        .rdata   (rdata),
        .miss    (miss),
        .events  (events),
        .mem_req (mem_req),
        .mem_resp(mem_resp)
    );

    backing_memory mem0 (
        .clock(clock),
        .reset(reset),
        .req  (mem_req),
        .resp (mem_resp)
    );

endmodule

`default_nettype wire

// File: test/memsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memsys_tb;

    localparam int max_vectors = 64;
    localparam int reset_cycles = 10;
    localparam int access_budget = 2 * memsys_pkg::mem_latency + 8;
    localparam string vector_path = "test/memsys_vectors.txt";

    logic clock;
    logic reset;
    memsys_pkg::apb_req_t apb;
    memsys_pkg::apb_resp_t apb_rsp;
    memsys_pkg::core_req_t core_req;
    logic [memsys_pkg::xlen-1:0] rdata;
    logic miss;

    // one entry per vector line
    logic [8*24-1:0] vec_name [max_vectors];
    logic [8*24-1:0] vec_op [max_vectors];
    logic [2:0] vec_load [max_vectors];
    logic [2:0] vec_store [max_vectors];
    logic vec_signed [max_vectors];
    logic [63:0] vec_addr [max_vectors];
    logic [63:0] vec_wdata [max_vectors];
    logic vec_flag [max_vectors];
    logic [63:0] vec_expect [max_vectors];
    int num_vectors;
    int cycle_limit;
    int cycle_count;

    memsys_top dut0 (
        .clock   (clock),
        .reset   (reset),
        .apb     (apb),
        .apb_rsp (apb_rsp),
        .core_req(core_req),
        .rdata   (rdata),
        .miss    (miss)
    );

    always #2 clock = ~clock;

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on failure");
    endtask

    task automatic check_data(input logic [8*24-1:0] name,
                              input logic [memsys_pkg::xlen-1:0] expected,
                              input logic [memsys_pkg::xlen-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %0s rdata expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_apb(input logic [8*24-1:0] name,
                             input memsys_pkg::apb_resp_t expected,
                             input memsys_pkg::apb_resp_t actual);
        if (actual !== expected) begin
            $display("ERROR %0s apb expected rd %h rdy %b err %b actual rd %h rdy %b err %b",
                     name, expected.prdata, expected.pready, expected.pslverr,
                     actual.prdata, actual.pready, actual.pslverr);
            abort_run();
        end
    endtask

    task automatic check_miss(input logic [8*24-1:0] name, input logic expected,
                              input logic actual);
        if (actual !== expected) begin
            $display("ERROR %0s miss expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    // lines starting with a lone # are comments
    task automatic read_vectors();
        int fd;
        int code;
        logic [8*24-1:0] tok;
        logic [8*24-1:0] op;
        logic [63:0] f_load;
        logic [63:0] f_store;
        logic [63:0] f_signed;
        logic [63:0] f_addr;
        logic [63:0] f_wdata;
        logic [63:0] f_flag;
        logic [63:0] f_expect;
        logic [8*128-1:0] rest;
        fd = $fopen(vector_path, "r");
        if (fd == 0) begin
            $display("could not open the vector file %s", vector_path);
            abort_run();
        end
        num_vectors = 0;
        forever begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (tok == "#") begin
                code = $fgets(rest, fd);
                continue;
            end
            code = $fscanf(fd, "%s %h %h %h %h %h %h %h", op, f_load, f_store, f_signed,
                           f_addr, f_wdata, f_flag, f_expect);
            if (code != 8 || num_vectors >= max_vectors) begin
                $display("vector line %0d is malformed or there are too many", num_vectors + 1);
                abort_run();
            end
            vec_name[num_vectors] = tok;
            vec_op[num_vectors] = op;
            vec_load[num_vectors] = f_load[2:0];
            vec_store[num_vectors] = f_store[2:0];
            vec_signed[num_vectors] = f_signed[0];
            vec_addr[num_vectors] = f_addr;
            vec_wdata[num_vectors] = f_wdata;
            vec_flag[num_vectors] = f_flag[0];
            vec_expect[num_vectors] = f_expect;
            num_vectors++;
        end
        $fclose(fd);
    endtask

    // hold the request until an edge with miss low
    task automatic run_access(input int i);
        memsys_pkg::core_req_t req;
        int waited;
        req.load_type = memsys_pkg::load_type_t'(vec_load[i]);
        req.store_type = memsys_pkg::store_type_t'(vec_store[i]);
        req.signed_type = vec_signed[i];
        req.addr = vec_addr[i];
        req.wdata = vec_wdata[i];
        @(posedge clock);
        core_req <= req;
        @(negedge clock);
        check_miss(vec_name[i], vec_flag[i], miss);
        waited = 0;
        while (miss) begin
            if (waited >= access_budget) begin
                $display("access %0s did not complete within %0d cycles", vec_name[i],
                         access_budget);
                abort_run();
            end
            @(negedge clock);
            waited++;
        end
        @(posedge clock);
        core_req <= '0;
        @(negedge clock);
        check_data(vec_name[i], vec_expect[i], rdata);
    endtask

    task automatic run_apb(input int i, input logic write);
        memsys_pkg::apb_req_t req;
        memsys_pkg::apb_resp_t expected;
        req.psel = 1'b1;
        req.penable = 1'b0;
        req.pwrite = write;
        req.paddr = vec_addr[i][11:0];
        req.pwdata = vec_wdata[i][31:0];
        expected.prdata = vec_expect[i][31:0];
        expected.pready = 1'b1;
        expected.pslverr = vec_flag[i];
        @(posedge clock);
        apb <= req;
        req.penable = 1'b1;
        @(posedge clock);
        apb <= req;
        @(negedge clock);
        check_apb(vec_name[i], expected, apb_rsp);
        @(posedge clock);
        apb <= '0;
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        apb = '0;
        core_req = '0;
        cycle_count = 0;
        cycle_limit = 0;
        read_vectors();
        cycle_limit = num_vectors * access_budget + reset_cycles;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < num_vectors; i++) begin
            if (vec_op[i] == "access") begin
                run_access(i);
            end else if (vec_op[i] == "apb_write") begin
                run_apb(i, 1'b1);
            end else if (vec_op[i] == "apb_read") begin
                run_apb(i, 1'b0);
            end else begin
                $display("vector %0s has an unknown operation", vec_name[i]);
                abort_run();
            end
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: memsys.f
verilog/memsys_pkg.sv
verilog/byte_lane_unit.sv
verilog/l1_data_cache.sv
verilog/backing_memory.sv
verilog/cache_csr.sv
verilog/memsys_top.sv
test/memsys_tb.sv

// File: test/memsys_vectors.txt
# name op load store signed addr wdata flag expect (hex fields, 1=byte 2=half 3=word 4=dword)
# flag is first-cycle miss for access and pslverr for apb; expect is rdata or prdata
cold_load access 4 0 0 0000 0 1 5d5c5f5e59585b5a
reload_hit access 4 0 0 0008 0 0 5554575651505352
ldb_s_c0 access 1 0 1 00c0 0 1 ffffffffffffff9a
ldb_u_c1 access 1 0 0 00c1 0 0 000000000000009b
ldh_s_c2 access 2 0 1 00c2 0 0 ffffffffffff9998
ldh_u_c4 access 2 0 0 00c4 0 0 0000000000009f9e
ldw_s_c8 access 3 0 1 00c8 0 0 ffffffff91909392
ldw_u_cc access 3 0 0 00cc 0 0 0000000095949796
ldd_f8 access 4 0 0 00f8 0 0 a5a4a7a6a1a0a3a2
std_100 access 0 4 0 0100 1122334455667788 1 a5a4a7a6a1a0a3a2
stb_101 access 0 1 0 0101 ffffffffffffffab 0 a5a4a7a6a1a0a3a2
sth_106 access 0 2 0 0106 0123456789abcdef 0 a5a4a7a6a1a0a3a2
stw_108 access 0 3 0 0108 12345678deadbeef 0 a5a4a7a6a1a0a3a2
ldd_100_merged access 4 0 0 0100 0 0 cdef33445566ab88
ldw_s_108 access 3 0 1 0108 0 0 ffffffffdeadbeef
ldd_108 access 4 0 0 0108 0 0 55545756deadbeef
ld_900_fill access 4 0 0 0900 0 1 5d5c5f5e59585b5a
ld_1100_evict access 4 0 0 1100 0 1 5d5c5f5e59585b5a
ld_900_kept access 4 0 0 0900 0 0 5d5c5f5e59585b5a
ld_100_back access 4 0 0 0100 0 1 cdef33445566ab88
rd_access apb_read 0 0 0 004 0 0 14
rd_refill apb_read 0 0 0 008 0 0 6
rd_writeback apb_read 0 0 0 00c 0 0 1
clr_access apb_write 0 0 0 004 0 0 0
rd_access_clr apb_read 0 0 0 004 0 0 0
rd_unmapped apb_read 0 0 0 010 0 1 0
dis_write apb_write 0 0 0 000 0 0 0
dis_load access 4 0 0 0040 0 0 cdef33445566ab88
dis_rd_access apb_read 0 0 0 004 0 0 0
en_write apb_write 0 0 0 000 1 0 0
en_load access 4 0 0 0040 0 1 1d1c1f1e19181b1a
en_rd_access apb_read 0 0 0 004 0 0 1
en_rd_refill apb_read 0 0 0 008 0 0 7
